// File: tb.f
logic/rv_decode_pkg.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/decoder.sv
logic/decode_front_end.sv
dv/decode_front_end_assertions.sv
dv/decode_front_end_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the front end testbench with Verilator and runs it
# exit status is nonzero unless the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module decode_front_end_tb \
	-o sim_tb || exit 1
./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Done: no errors$" && exit 0 || exit 1

// File: dv/decode_front_end_tb.sv
// directed testbench for the decode front end
// memory model answers one cycle after imem_req, a monitor checks every
// decoded_valid beat against a reference decode of the word at the expected pc

`timescale 1ns/1ps

module decode_front_end_tb;
	import rv_decode_pkg::*;

	logic          clock;
	logic          arst_n;
	logic          fetch_en;
	logic          flush;
	logic [31:0]   flush_pc;
	logic          dispatch_stall;
	logic          imem_req;
	logic [31:0]   imem_addr;
	logic [31:0]   imem_data;
	decoded_pack_t decoded;
	logic          decoded_valid;

	// 256 word instruction memory, byte address bits 9:2
	logic [31:0] imem [256];
	logic [31:0] exp_pc;
	int          beats;
	int          cycles;
	int          errors;
	logic [31:0] seed;

	decode_front_end decode_front_end_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// word comes back one cycle after the request
	always @(posedge clock) begin
		if (imem_req) begin
			imem_data <= imem[imem_addr[9:2]];
		end
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check_eq(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// add and sub share f3 0, srl and sra share f3 5
	function automatic alu_func_t alu_of_f3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? ALU_SUB : ALU_ADD;
			3'd1: return ALU_SLL;
			3'd2: return ALU_SLT;
			3'd3: return ALU_SLTU;
			3'd4: return ALU_XOR;
			3'd5: return alt ? ALU_SRA : ALU_SRL;
			3'd6: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic decoded_pack_t blank_pack(input logic [31:0] pc);
		decoded_pack_t d;
		d          = '0;
		d.pc       = pc;
		d.fu       = FU_ALU;
		d.alu_func = ALU_ADD;
		d.opa_sel  = OPA_RS1;
		d.opb_sel  = OPB_RS2;
		return d;
	endfunction

	// expected packet straight from the rv32im encoding rules
	function automatic decoded_pack_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
		decoded_pack_t d;
		logic [2:0]    f3;
		logic [6:0]    f7;
		logic [31:0]   i_imm;
		logic          ill;
		d     = blank_pack(pc);
		f3    = w[14:12];
		f7    = w[31:25];
		i_imm = $signed(w) >>> 20;
		ill   = 1'b0;
		case (w[6:0])
			7'h37, 7'h17: begin
				// lui has bit 5 set, auipc not
				d.arch_reg.dest = w[11:7];
				d.opa_sel       = w[5] ? OPA_ZERO : OPA_PC;
				d.opb_sel       = OPB_U_IMM;
				d.imm           = {w[31:12], 12'h0};
			end
			7'h6f: begin
				d.fu            = FU_BRANCH;
				d.arch_reg.dest = w[11:7];
				d.opa_sel       = OPA_PC;
				d.opb_sel       = OPB_J_IMM;
				d.imm           = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				d.uncond_branch = 1'b1;
			end
			7'h67: begin
				d.fu            = FU_BRANCH;
				d.arch_reg.dest = w[11:7];
				d.arch_reg.src1 = w[19:15];
				d.opb_sel       = OPB_I_IMM;
				d.imm           = i_imm;
				d.uncond_branch = 1'b1;
				ill             = (f3 != 3'd0);
			end
			7'h63: begin
				d.fu            = FU_BRANCH;
				d.arch_reg.src1 = w[19:15];
				d.arch_reg.src2 = w[24:20];
				d.opa_sel       = OPA_PC;
				d.opb_sel       = OPB_B_IMM;
				d.imm           = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				d.cond_branch   = 1'b1;
				ill             = (f3 == 3'd2) || (f3 == 3'd3);
			end
			7'h03: begin
				d.fu            = FU_MEM;
				d.arch_reg.dest = w[11:7];
				d.arch_reg.src1 = w[19:15];
				d.opb_sel       = OPB_I_IMM;
				d.imm           = i_imm;
				d.rd_mem        = 1'b1;
				ill             = (f3 == 3'd3) || (f3 > 3'd5);
			end
			7'h23: begin
				d.fu            = FU_MEM;
				d.arch_reg.src1 = w[19:15];
				d.arch_reg.src2 = w[24:20];
				d.opb_sel       = OPB_S_IMM;
				d.imm           = {i_imm[31:5], w[11:7]};
				d.wr_mem        = 1'b1;
				ill             = (f3 > 3'd2);
			end
			7'h13: begin
				d.arch_reg.dest = w[11:7];
				d.arch_reg.src1 = w[19:15];
				d.opb_sel       = OPB_I_IMM;
				d.imm           = i_imm;
				d.alu_func      = alu_of_f3(f3, (f3 == 3'd5) && f7[5]);
				if (f3 == 3'd1) begin
					ill = (f7 != 7'h00);
				end else if (f3 == 3'd5) begin
					ill = (f7 != 7'h00) && (f7 != 7'h20);
				end
			end
			7'h33: begin
				d.arch_reg.dest = w[11:7];
				d.arch_reg.src1 = w[19:15];
				d.arch_reg.src2 = w[24:20];
				if (f7 == 7'h01) begin
					d.fu = FU_MULT;
					case (f3)
						3'd0: d.alu_func = ALU_MUL;
						3'd1: d.alu_func = ALU_MULH;
						3'd2: d.alu_func = ALU_MULHSU;
						3'd3: d.alu_func = ALU_MULHU;
						default: ill = 1'b1;
					endcase
				end else if (f7 == 7'h00) begin
					d.alu_func = alu_of_f3(f3, 1'b0);
				end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
					d.alu_func = alu_of_f3(f3, 1'b1);
				end else begin
					ill = 1'b1;
				end
			end
			7'h73: begin
				if (w == 32'h1050_0073) begin
					d.halt = 1'b1;
				end else if (f3 != 3'd0 && f3 < 3'd4) begin
					d.csr_op = 1'b1;
				end else begin
					ill = 1'b1;
				end
			end
			default: ill = 1'b1;
		endcase
		if (ill) begin
			d         = blank_pack(pc);
			d.illegal = 1'b1;
		end
		return d;
	endfunction

	// sampled on the rising edge, values set up since the last edge
	always @(posedge clock) begin
		if (decoded_valid) begin
			check_eq("decoded.pc", 128'(decoded.pc), 128'(exp_pc));
			check_eq("decoded", 128'(decoded), 128'(ref_decode(exp_pc, imem[exp_pc[9:2]])));
			exp_pc = exp_pc + 32'd4;
			beats++;
		end
		if (flush) begin
			exp_pc = flush_pc;
		end
	end

	// watchdog, generous against the summed test lengths
	always @(posedge clock) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("timeout waiting for decoded instructions");
			$display("Done: errors found");
			$fatal(1);
		end
	end

	task automatic redirect(input logic [31:0] pc);
		@(negedge clock);
		flush    = 1'b1;
		flush_pc = pc;
		fetch_en = 1'b1;
		@(negedge clock);
		flush = 1'b0;
	endtask

	// beat count settles on the rising edge, look at it on the falling one
	task automatic wait_beats(input int n);
		int target;
		target = beats + n;
		while (beats < target) begin
			@(negedge clock);
		end
	endtask

	// one word per opcode class, straight line from 0x000
	task automatic test_in_order();
		logic [31:0] prog [14];
		prog = '{32'h123450b7, 32'h00001117, 32'h008001ef, 32'h00008267,
			32'h00208463, 32'h0040a283, 32'h0050a423, 32'hfff08313,
			32'h40335393, 32'h00208433, 32'h40208433, 32'h022084b3,
			32'h0220b4b3, 32'h34029073};
		foreach (prog[i]) begin
			imem[i] = prog[i];
		end
		redirect(32'h000);
		wait_beats(14);
	endtask

	// random i, s, b, u and j words from 0x100
	task automatic test_immediates();
		logic [31:0] r;
		for (int i = 0; i < 40; i++) begin
			r = lcg_next();
			case (i % 5)
				0: imem[64 + i] = (r & 32'hffff8f80) | 32'h13;
				1: imem[64 + i] = (r & 32'hffff8f80) | 32'h23;
				2: imem[64 + i] = (r & 32'hffff8f80) | 32'h63;
				3: imem[64 + i] = (r & 32'hffffff80) | 32'h37;
				default: imem[64 + i] = (r & 32'hffffff80) | 32'h6f;
			endcase
		end
		redirect(32'h100);
		wait_beats(40);
	endtask

	// fence, ecall, div, bad load and shift encodings, csr and wfi
	task automatic test_flags();
		logic [31:0] prog [8];
		prog = '{32'h0000000f, 32'h00000073, 32'h342022f3, 32'h10500073,
			32'hffffffff, 32'h02004033, 32'h00003003, 32'h40001013};
		foreach (prog[i]) begin
			imem[128 + i] = prog[i];
		end
		redirect(32'h200);
		wait_beats(8);
	endtask

	// long stall, then the same sequence must carry on
	task automatic test_backpressure();
		int held;
		for (int i = 0; i < 24; i++) begin
			imem[160 + i] = (lcg_next() & 32'hfffff07f) | 32'h33;
		end
		redirect(32'h280);
		wait_beats(3);
		@(negedge clock);
		dispatch_stall = 1'b1;
		repeat (2) @(negedge clock);
		held = beats;
		// queue is full by now, fetch has to sit idle
		repeat (30) begin
			@(negedge clock);
			check_eq("imem_req", 128'(imem_req), 128'(1'b0));
		end
		check_eq("beats under stall", 128'(beats), 128'(held));
		dispatch_stall = 1'b0;
		wait_beats(20);
	endtask

	// redirect in the middle of a running stream
	task automatic test_flush();
		for (int i = 0; i < 32; i++) begin
			imem[192 + i] = (lcg_next() & 32'hffff8f80) | 32'h13;
		end
		redirect(32'h300);
		wait_beats(5);
		redirect(32'h340);
		wait_beats(12);
	endtask

	initial begin
		arst_n         = 1'b0;
		fetch_en       = 1'b0;
		flush          = 1'b0;
		flush_pc       = '0;
		dispatch_stall = 1'b0;
		imem_data      = '0;
		exp_pc         = '0;
		beats          = 0;
		cycles         = 0;
		errors         = 0;
		seed           = 32'hec7dc1c3;
		// background words, mostly illegal, tied to every address bit
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i * 32'h9e37_79b1) ^ {24'h0, i[7:0]};
		end
		repeat (8) @(negedge clock);
		arst_n = 1'b1;
		test_in_order();
		test_immediates();
		test_flags();
		test_backpressure();
		test_flush();
		repeat (4) @(negedge clock);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: dv/decode_front_end_assertions.sv
// protocol checks on the queue and the decoded output
// bound into the front end top, sees the internal fetch, queue and decode wires

`timescale 1ns/1ps

module frontend_assertions (
	input logic                                clock,
	input logic                                arst_n,
	input logic                                push,
	input logic                                pop,
	input logic                                not_empty,
	input logic [rv_decode_pkg::QUEUE_PTR_W:0] free_slots,
	input logic                                flush,
	input logic                                decoded_valid
);
	// queue occupancy rebuilt from the push and pop strobes
	int occupancy;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			occupancy <= 0;
		end else if (flush) begin
			occupancy <= 0;
		end else begin
			occupancy <= occupancy + int'(push) - int'(pop);
		end
	end

	// fetch must respect the room check
	no_push_when_full: assert property (@(posedge clock) disable iff (!arst_n)
		push |-> (free_slots != '0))
		else $error("push into a full instruction queue");

	// decoder only pops a queue that holds something
	no_pop_when_empty: assert property (@(posedge clock) disable iff (!arst_n)
		pop |-> (occupancy > 0))
		else $error("pop from an empty instruction queue");

	// output strobe stays quiet in reset
	valid_low_in_reset: assert property (@(posedge clock)
		!arst_n |-> !decoded_valid)
		else $error("decoded_valid high during reset");

	// flush kills the packet register
	valid_low_after_flush: assert property (@(posedge clock) disable iff (!arst_n)
		flush |=> !decoded_valid)
		else $error("decoded_valid high on the cycle after a flush");

endmodule

bind decode_front_end frontend_assertions frontend_assertions_i (.*);

// File: logic/decode_front_end.sv
// top of the front end, fetch feeds the queue and decode drains it
// imem is external and answers one cycle after imem_req
// flush redirects fetch to flush_pc and drops queued and decoded work

`timescale 1ns/1ps

module decode_front_end (
	input  logic                          clock,
	input  logic                          arst_n,
	input  logic                          fetch_en,
	input  logic                          flush,
	input  logic [rv_decode_pkg::XLEN-1:0] flush_pc,
	input  logic                          dispatch_stall,
	output logic                          imem_req,
	output logic [rv_decode_pkg::XLEN-1:0] imem_addr,
	input  logic [rv_decode_pkg::XLEN-1:0] imem_data,
	output rv_decode_pkg::decoded_pack_t  decoded,
	output logic                          decoded_valid
);
	import rv_decode_pkg::*;

	// fetch to queue
	logic                 push;
	fetch_entry_t         push_entry;
	logic [QUEUE_PTR_W:0] free_slots;
	// queue to decode
	fetch_entry_t         head;
	logic                 not_empty;
	logic                 pop;

	fetch_unit fetch_unit_i (
		.clock      (clock),
		.arst_n     (arst_n),
		.fetch_en   (fetch_en),
		.flush      (flush),
		.flush_pc   (flush_pc),
		.free_slots (free_slots),
		.imem_data  (imem_data),
		.imem_req   (imem_req),
		.imem_addr  (imem_addr),
		.push       (push),
		.push_entry (push_entry)
	);

	inst_queue inst_queue_i (
		.clock      (clock),
		.arst_n     (arst_n),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.flush      (flush),
		.head       (head),
		.not_empty  (not_empty),
		.free_slots (free_slots)
	);

	decoder decoder_i (
		.clock          (clock),
		.arst_n         (arst_n),
		.head           (head),
		.not_empty      (not_empty),
		.dispatch_stall (dispatch_stall),
		.flush          (flush),
		.pop            (pop),
		.decoded        (decoded),
		.decoded_valid  (decoded_valid)
	);

endmodule

// File: logic/decoder.sv
// rv32im decode of the queue head into the packet for dispatch
// decode itself is combinational, the result is registered on pop
// decoded_valid is a one cycle strobe per decoded instruction

`timescale 1ns/1ps

module decoder (
	input  logic                          clock,
	input  logic                          arst_n,
	input  rv_decode_pkg::fetch_entry_t   head,
	input  logic                          not_empty,
	input  logic                          dispatch_stall,
	input  logic                          flush,
	output logic                          pop,
	output rv_decode_pkg::decoded_pack_t  decoded,
	output logic                          decoded_valid
);
	import rv_decode_pkg::*;

	logic [31:0]     inst;
	opcode_t         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] i_imm;
	logic [XLEN-1:0] s_imm;
	logic [XLEN-1:0] b_imm;
	logic [XLEN-1:0] u_imm;
	logic [XLEN-1:0] j_imm;
	decoded_pack_t   dec;

	// noop packet, alu add of rs1 and rs2 with all regs at x0
	function automatic decoded_pack_t noop_pack(input logic [XLEN-1:0] pc);
		decoded_pack_t p;
		p          = '0;
		p.pc       = pc;
		p.fu       = FU_ALU;
		p.alu_func = ALU_ADD;
		p.opa_sel  = OPA_RS1;
		p.opb_sel  = OPB_RS2;
		return p;
	endfunction

	assign inst   = head.inst;
	// values outside the enum fall to the default arm
	assign opcode = opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// sign extended immediates per format
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign u_imm = {inst[31:12], 12'b0};
	assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec = noop_pack(head.pc);
		case (opcode)
			OP_LUI: begin
				dec.arch_reg.dest = inst[11:7];
				dec.opa_sel       = OPA_ZERO;
				dec.opb_sel       = OPB_U_IMM;
				dec.imm           = u_imm;
			end
			OP_AUIPC: begin
				dec.arch_reg.dest = inst[11:7];
				dec.opa_sel       = OPA_PC;
				dec.opb_sel       = OPB_U_IMM;
				dec.imm           = u_imm;
			end
			OP_JAL: begin
				dec.fu            = FU_BRANCH;
				dec.arch_reg.dest = inst[11:7];
				dec.opa_sel       = OPA_PC;
				dec.opb_sel       = OPB_J_IMM;
				dec.imm           = j_imm;
				dec.uncond_branch = 1'b1;
			end
			OP_JALR: begin
				dec.fu            = FU_BRANCH;
				dec.arch_reg.dest = inst[11:7];
				dec.arch_reg.src1 = inst[19:15];
				dec.opb_sel       = OPB_I_IMM;
				dec.imm           = i_imm;
				dec.uncond_branch = 1'b1;
				dec.illegal       = (funct3 != 3'b000);
			end
			OP_BRANCH: begin
				// target is pc plus b_imm, no dest
				dec.fu            = FU_BRANCH;
				dec.arch_reg.src1 = inst[19:15];
				dec.arch_reg.src2 = inst[24:20];
				dec.opa_sel       = OPA_PC;
				dec.opb_sel       = OPB_B_IMM;
				dec.imm           = b_imm;
				dec.cond_branch   = 1'b1;
				// funct3 010 and 011 unused
				dec.illegal       = (funct3[2:1] == 2'b01);
			end
			OP_LOAD: begin
				dec.fu            = FU_MEM;
				dec.arch_reg.dest = inst[11:7];
				dec.arch_reg.src1 = inst[19:15];
				dec.opb_sel       = OPB_I_IMM;
				dec.imm           = i_imm;
				dec.rd_mem        = 1'b1;
				// lb lh lw lbu lhu only
				dec.illegal       = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			OP_STORE: begin
				dec.fu            = FU_MEM;
				dec.arch_reg.src1 = inst[19:15];
				dec.arch_reg.src2 = inst[24:20];
				dec.opb_sel       = OPB_S_IMM;
				dec.imm           = s_imm;
				dec.wr_mem        = 1'b1;
				// sb sh sw only
				dec.illegal       = (funct3 > 3'b010);
			end
			OP_IMM: begin
				dec.arch_reg.dest = inst[11:7];
				dec.arch_reg.src1 = inst[19:15];
				dec.opb_sel       = OPB_I_IMM;
				dec.imm           = i_imm;
				case (funct3)
					3'b000: dec.alu_func = ALU_ADD;
					3'b010: dec.alu_func = ALU_SLT;
					3'b011: dec.alu_func = ALU_SLTU;
					3'b100: dec.alu_func = ALU_XOR;
					3'b110: dec.alu_func = ALU_OR;
					3'b111: dec.alu_func = ALU_AND;
					3'b001: begin
						dec.alu_func = ALU_SLL;
						dec.illegal  = (funct7 != F7_BASE);
					end
					default: begin
						// srli or srai by funct7
						dec.alu_func = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						dec.illegal  = (funct7 != F7_BASE) && (funct7 != F7_ALT);
					end
				endcase
			end
			OP_REG: begin
				dec.arch_reg.dest = inst[11:7];
				dec.arch_reg.src1 = inst[19:15];
				dec.arch_reg.src2 = inst[24:20];
				if (funct7 == F7_MUL) begin
					// mul group, div and rem not supported
					dec.fu = FU_MULT;
					case (funct3)
						3'b000:  dec.alu_func = ALU_MUL;
						3'b001:  dec.alu_func = ALU_MULH;
						3'b010:  dec.alu_func = ALU_MULHSU;
						3'b011:  dec.alu_func = ALU_MULHU;
						default: dec.illegal  = 1'b1;
					endcase
				end else if (funct7 == F7_ALT) begin
					case (funct3)
						3'b000:  dec.alu_func = ALU_SUB;
						3'b101:  dec.alu_func = ALU_SRA;
						default: dec.illegal  = 1'b1;
					endcase
				end else if (funct7 == F7_BASE) begin
					case (funct3)
						3'b000:  dec.alu_func = ALU_ADD;
						3'b001:  dec.alu_func = ALU_SLL;
						3'b010:  dec.alu_func = ALU_SLT;
						3'b011:  dec.alu_func = ALU_SLTU;
						3'b100:  dec.alu_func = ALU_XOR;
						3'b101:  dec.alu_func = ALU_SRL;
						3'b110:  dec.alu_func = ALU_OR;
						default: dec.alu_func = ALU_AND;
					endcase
				end else begin
					dec.illegal = 1'b1;
				end
			end
			OP_SYSTEM: begin
				// csrrw csrrs csrrc are only flagged
				if (inst == WFI_INST) begin
					dec.halt = 1'b1;
				end else if (funct3 == 3'b001 || funct3 == 3'b010 || funct3 == 3'b011) begin
					dec.csr_op = 1'b1;
				end else begin
					// ecall, ebreak and the rest
					dec.illegal = 1'b1;
				end
			end
			default: dec.illegal = 1'b1;
		endcase
		// an illegal word leaves only its pc and the flag
		if (dec.illegal) begin
			dec         = noop_pack(head.pc);
			dec.illegal = 1'b1;
		end
	end

	assign pop = not_empty && !dispatch_stall;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			decoded_valid <= 1'b0;
		end else begin
			// flush wins over a pop on the same edge
			decoded_valid <= pop && !flush;
		end
	end

	// packet register
	always_ff @(posedge clock) begin
		if (pop && !flush) begin
			decoded <= dec;
		end
	end

endmodule

// File: logic/inst_queue.sv
// small circular fifo between fetch and decode
// entry pushed at an edge is at the head right after it
// push and pop may come together, flush drops everything

`timescale 1ns/1ps

module inst_queue (
	input  logic                                clock,
	input  logic                                arst_n,
	input  logic                                push,
	input  rv_decode_pkg::fetch_entry_t         push_entry,
	input  logic                                pop,
	input  logic                                flush,
	output rv_decode_pkg::fetch_entry_t         head,
	output logic                                not_empty,
	output logic [rv_decode_pkg::QUEUE_PTR_W:0] free_slots
);
	import rv_decode_pkg::*;

	// storage, no reset needed
	fetch_entry_t mem [QUEUE_DEPTH];

	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	// occupancy, one bit wider than the pointers
	logic [QUEUE_PTR_W:0]   count;

	logic do_push;
	logic do_pop;

	// fetch never pushes into a full queue
	// decoder only pops when not_empty
	assign do_push = push && !flush;
	assign do_pop  = pop && not_empty && !flush;

	assign head       = mem[rd_ptr];
	assign not_empty  = (count != '0);
	assign free_slots = (QUEUE_PTR_W + 1)'(QUEUE_DEPTH) - count;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// write port
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

endmodule

// File: logic/fetch_unit.sv
// fetch stage, walks the pc and reads the external instruction memory
// memory answers one cycle after imem_req, the word is pushed with its pc
// requests only go out while the queue has room for them

`timescale 1ns/1ps

module fetch_unit (
	input  logic                               clock,
	input  logic                               arst_n,
	input  logic                               fetch_en,
	input  logic                               flush,
	input  logic [rv_decode_pkg::XLEN-1:0]     flush_pc,
	input  logic [rv_decode_pkg::QUEUE_PTR_W:0] free_slots,
	input  logic [rv_decode_pkg::XLEN-1:0]     imem_data,
	output logic                               imem_req,
	output logic [rv_decode_pkg::XLEN-1:0]     imem_addr,
	output logic                               push,
	output rv_decode_pkg::fetch_entry_t        push_entry
);
	import rv_decode_pkg::*;

	// next pc to request
	logic [XLEN-1:0] pc;
	// a reply is on imem_data this cycle
	logic            pending;
	// pc that belongs to the reply in flight
	logic [XLEN-1:0] inflight_pc;
	// outstanding requests widened to the slot count
	logic [QUEUE_PTR_W:0] pending_cnt;

	assign pending_cnt = {{QUEUE_PTR_W{1'b0}}, pending};

	// room check counts the reply still on its way
	// the slot freed by a pop this cycle is not counted yet
	assign imem_req  = fetch_en && !flush && (free_slots > pending_cnt);
	assign imem_addr = pc;

	// a flush kills the word coming back this cycle
	assign push            = pending && !flush;
	assign push_entry.pc   = inflight_pc;
	assign push_entry.inst = imem_data;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= '0;
			pending <= 1'b0;
		end else begin
			// imem_req is already low during flush
			pending <= imem_req;
			if (flush) begin
				pc <= flush_pc;
			end else if (imem_req) begin
				pc <= pc + XLEN'(4);
			end
		end
	end

	// remember which pc was asked for
	always_ff @(posedge clock) begin
		if (imem_req) begin
			inflight_pc <= pc;
		end
	end

endmodule

// File: logic/rv_decode_pkg.sv
// shared widths, enums and packed structs for the rv32im decode front end
// imported by the fetch, queue and decode rtl and by the testbench

package rv_decode_pkg;

	// data and address width
	localparam int XLEN        = 32;
	// instruction queue size, pointer width matches the depth
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = 2;

	// funct7 groups for op and op-imm shifts
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;
	localparam logic [6:0] F7_MUL  = 7'b0000001;

	// wfi is one fixed encoding inside the system opcode
	localparam logic [31:0] WFI_INST = 32'h1050_0073;

	// major opcodes, inst[6:0]
	// fence and misc-mem are left out on purpose, they land in illegal
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_t;

	// alu and multiplier functions
	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_SLT    = 4'h2,
		ALU_SLTU   = 4'h3,
		ALU_AND    = 4'h4,
		ALU_OR     = 4'h5,
		ALU_XOR    = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha,
		ALU_MULH   = 4'hb,
		ALU_MULHSU = 4'hc,
		ALU_MULHU  = 4'hd
	} alu_func_t;

	// functional unit class, alu stays at 2'b11
	typedef enum logic [1:0] {
		FU_MEM    = 2'b00,
		FU_BRANCH = 2'b01,
		FU_MULT   = 2'b10,
		FU_ALU    = 2'b11
	} fu_sel_t;

	// operand a source
	typedef enum logic [1:0] {
		OPA_RS1  = 2'b00,
		OPA_PC   = 2'b01,
		OPA_ZERO = 2'b10
	} opa_sel_t;

	// operand b source
	typedef enum logic [2:0] {
		OPB_RS2   = 3'd0,
		OPB_I_IMM = 3'd1,
		OPB_S_IMM = 3'd2,
		OPB_B_IMM = 3'd3,
		OPB_U_IMM = 3'd4,
		OPB_J_IMM = 3'd5
	} opb_sel_t;

	// queue payload, one fetched word with its own pc
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
	} fetch_entry_t;

	// architectural register numbers
	typedef struct packed {
		logic [4:0] src1;
		logic [4:0] src2;
		logic [4:0] dest;
	} arch_regs_t;

	// decoded packet handed to dispatch
	typedef struct packed {
		logic [XLEN-1:0] pc;
		fu_sel_t         fu;
		arch_regs_t      arch_reg;
		logic [XLEN-1:0] imm;
		alu_func_t       alu_func;
		opa_sel_t        opa_sel;
		opb_sel_t        opb_sel;
		logic            rd_mem;
		logic            wr_mem;
		logic            cond_branch;
		logic            uncond_branch;
		logic            csr_op;
		logic            halt;
		logic            illegal;
	} decoded_pack_t;

endpackage
